//--- sim.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/fetch_ctrl.sv
verilog/apb_wait_timer.sv
verilog/fetch_unit_top.sv
testbench/tb_apb_imem.sv
testbench/tb_fetch_unit.sv

//--- Makefile
# Verilator build and run for the fetch front end testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP      ?= tb_fetch_unit
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_fetch_unit.sv
// Testbench for the instruction fetch front end
// Directed tests: sequential fetch, redirects, branch prediction,
// misaligned fetch, APB access faults and stall
`timescale 1ns/1ps

module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam addr_t       RESET_PC = 32'h0000_1000;
    localparam logic [31:0] MEM_KEY  = 32'h5a5a_0000;
    localparam int          MAX_WAIT = 60;

    logic            clk = 1'b0;
    logic            rstn;
    addr_t           reset_addr;
    logic            stall;
    redirect_t       redirect;
    branch_resolve_t resolve;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    fetch_out_t      fetch;
    logic            fetch_ready;

    // Memory model controls
    logic [3:0]  mem_wait;
    logic        mem_slverr;
    logic        mem_hang;
    logic [31:0] mem_xfers;

    integer     seed;
    addr_t      exp_pc;
    // Expected 2-bit counter of the trained entry
    logic [1:0] ctr_model;

    always #2 clk = ~clk;

    fetch_unit_top #(
        .TIMEOUT_CYCLES (8)
    ) i_fetch_unit_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .reset_addr_i  (reset_addr),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .resolve_i     (resolve),
        .apb_o         (apb_req),
        .apb_i         (apb_rsp),
        .fetch_o       (fetch),
        .fetch_ready_i (fetch_ready)
    );

    tb_apb_imem i_imem (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .apb_i         (apb_req),
        .apb_o         (apb_rsp),
        .wait_states_i (mem_wait),
        .slverr_i      (mem_slverr),
        .hang_i        (mem_hang),
        .xfer_count_o  (mem_xfers)
    );

    // Inputs change 1 ns after the edge, outputs read there too
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h expected %0h", $time, name, got, exp);
            stop_with_failure("Value mismatch");
        end
    endtask

    task automatic wait_for_packet(input int max_cycles);
        int n;
        n = 0;
        while (!fetch.valid) begin
            if (n >= max_cycles) begin
                stop_with_failure("Timed out waiting for a fetch packet");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // APB ACCESS phase in progress
    task automatic wait_for_access(input int max_cycles);
        int n;
        n = 0;
        while (!(apb_req.psel && apb_req.penable)) begin
            if (n >= max_cycles) begin
                stop_with_failure("Timed out waiting for an APB access phase");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic accept_packet(output fetch_out_t p);
        fetch_ready = 1'b1;
        p = fetch;
        next_cycle();
        fetch_ready = 1'b0;
    endtask

    task automatic receive_packet(input int hold_cycles, output fetch_out_t p);
        fetch_out_t held;
        wait_for_packet(MAX_WAIT);
        held = fetch;
        // Back-pressure, packet must stay put
        repeat (hold_cycles) begin
            next_cycle();
            check_value("fetch_o.valid held", 64'(fetch.valid), 64'd1);
            check_value("fetch_o[63:0] held", fetch[63:0], held[63:0]);
            check_value("fetch_o[127:64] held", fetch[127:64], held[127:64]);
            check_value("fetch_o[135:128] held", 64'(fetch[135:128]),
                        64'(held[135:128]));
        end
        accept_packet(p);
    endtask

    task automatic check_word(input fetch_out_t p, input addr_t pc);
        check_value("fetch_o.pc", 64'(p.pc), 64'(pc));
        check_value("fetch_o.instr", 64'(p.instr), 64'(pc ^ MEM_KEY));
        check_value("fetch_o.ex.valid", 64'(p.ex.valid), 64'd0);
    endtask

    task automatic check_fault(input fetch_out_t p, input addr_t pc, input ex_cause_e cause);
        check_value("fetch_o.pc", 64'(p.pc), 64'(pc));
        check_value("fetch_o.ex.valid", 64'(p.ex.valid), 64'd1);
        check_value("fetch_o.ex.cause", 64'(p.ex.cause), 64'(cause));
        check_value("fetch_o.ex.origin", 64'(p.ex.origin), 64'(pc));
    endtask

    task automatic redirect_to(input addr_t pc);
        redirect.valid = 1'b1;
        redirect.pc    = pc;
        next_cycle();
        redirect.valid = 1'b0;
    endtask

    task automatic resolve_branch(input addr_t pc, input logic taken, input addr_t target);
        resolve.valid  = 1'b1;
        resolve.pc     = pc;
        resolve.taken  = taken;
        resolve.target = target;
        next_cycle();
        resolve.valid = 1'b0;
    endtask

    task automatic test_sequential(input int count);
        logic [31:0] rnd;
        fetch_out_t  p;
        int          i;
        for (i = 0; i < count; i++) begin
            rnd = $random(seed);
            mem_wait = {2'b00, rnd[3:2]};
            receive_packet(int'(rnd[1:0]), p);
            check_word(p, exp_pc);
            exp_pc = exp_pc + 32'd4;
        end
        mem_wait = '0;
    endtask

    task automatic test_redirect();
        fetch_out_t p;
        // Held packet dropped
        wait_for_packet(MAX_WAIT);
        redirect_to(32'h0000_1800);
        check_value("fetch_o.valid after redirect", 64'(fetch.valid), 64'd0);
        receive_packet(0, p);
        check_word(p, 32'h0000_1800);
        // Mid-transfer, slow memory
        mem_wait = 4'd6;
        wait_for_access(MAX_WAIT);
        redirect_to(32'h0000_1900);
        // Started transfer keeps its address to the end
        check_value("apb_o.penable after redirect", 64'(apb_req.penable), 64'd1);
        check_value("apb_o.paddr after redirect", 64'(apb_req.paddr),
                    64'(32'h0000_1804));
        receive_packet(0, p);
        check_word(p, 32'h0000_1900);
        mem_wait = '0;
    endtask

    task automatic test_branch_prediction();
        fetch_out_t p;
        addr_t      a;
        addr_t      t;
        a = 32'h0000_2040;
        t = 32'h0000_2400;
        // Taken miss allocates weakly taken
        resolve_branch(a, 1'b1, t);
        ctr_model = 2'd2;
        redirect_to(a);
        receive_packet(0, p);
        check_word(p, a);
        check_value("bpred.is_branch", 64'(p.bpred.is_branch), 64'd1);
        check_value("bpred.taken", 64'(p.bpred.taken), 64'd1);
        check_value("bpred.pred_addr", 64'(p.bpred.pred_addr), 64'(t));
        receive_packet(0, p);
        check_word(p, t);
        // Two not-taken outcomes, counter steps down
        repeat (2) begin
            resolve_branch(a, 1'b0, t);
            if (ctr_model != 2'd0) begin
                ctr_model = ctr_model - 2'd1;
            end
        end
        redirect_to(a);
        receive_packet(0, p);
        check_word(p, a);
        check_value("bpred.is_branch", 64'(p.bpred.is_branch), 64'd1);
        check_value("bpred.taken", 64'(p.bpred.taken), 64'(ctr_model[1]));
        check_value("bpred.pred_addr", 64'(p.bpred.pred_addr), 64'(t));
        receive_packet(0, p);
        check_word(p, ctr_model[1] ? t : a + 32'd4);
    endtask

    task automatic test_misaligned();
        fetch_out_t  p;
        logic [31:0] xfers;
        redirect_to(32'h0000_3002);
        xfers = mem_xfers;
        receive_packet(0, p);
        check_fault(p, 32'h0000_3002, INSTR_ADDR_MISALIGNED);
        check_value("APB transfer count", 64'(mem_xfers), 64'(xfers));
    endtask

    task automatic test_access_faults();
        fetch_out_t p;
        mem_slverr = 1'b1;
        redirect_to(32'h0000_4000);
        receive_packet(0, p);
        mem_slverr = 1'b0;
        check_fault(p, 32'h0000_4000, INSTR_ACCESS_FAULT);
        // No pready at all, the wait timer ends it
        mem_hang = 1'b1;
        redirect_to(32'h0000_4100);
        receive_packet(0, p);
        mem_hang = 1'b0;
        check_fault(p, 32'h0000_4100, INSTR_ACCESS_FAULT);
    endtask

    task automatic test_stall();
        fetch_out_t p;
        int         i;
        redirect_to(32'h0000_5000);
        wait_for_packet(MAX_WAIT);
        stall = 1'b1;
        accept_packet(p);
        check_word(p, 32'h0000_5000);
        for (i = 0; i < 20; i++) begin
            check_value("apb_o.psel during stall", 64'(apb_req.psel), 64'd0);
            check_value("fetch_o.valid during stall", 64'(fetch.valid), 64'd0);
            next_cycle();
        end
        stall = 1'b0;
        receive_packet(0, p);
        check_word(p, 32'h0000_5004);
    endtask

    initial begin
        rstn        = 1'b0;
        reset_addr  = RESET_PC;
        stall       = 1'b0;
        redirect    = '0;
        resolve     = '0;
        fetch_ready = 1'b0;
        mem_wait    = '0;
        mem_slverr  = 1'b0;
        mem_hang    = 1'b0;
        seed        = 32'hcdc2;
        exp_pc      = RESET_PC;
        ctr_model   = 2'd0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_sequential(24);
        test_redirect();
        test_branch_prediction();
        test_misaligned();
        test_access_faults();
        test_stall();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- testbench/tb_apb_imem.sv
// APB instruction memory model
// Returns paddr XOR 32'h5a5a0000 as the word, with programmable wait
// states, a slave error and a hang that never raises pready
`timescale 1ns/1ps

module tb_apb_imem
    import fetch_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  apb_req_t    apb_i,
    output apb_rsp_t    apb_o,
    // Wait cycles before pready in ACCESS
    input  logic [3:0]  wait_states_i,
    input  logic        slverr_i,
    input  logic        hang_i,
    // Number of SETUP phases seen
    output logic [31:0] xfer_count_o
);

    logic [3:0] wait_cnt_q;
    logic       access;
    logic       ready;

    assign access = apb_i.psel & apb_i.penable;

    // At or past the wait count so a lowered setting cannot hang
    assign ready = access & ~hang_i & (wait_cnt_q >= wait_states_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wait_cnt_q   <= '0;
            xfer_count_o <= '0;
        end else begin
            if (access && !ready) begin
                // Saturate during a hang
                if (wait_cnt_q != 4'hf) begin
                    wait_cnt_q <= wait_cnt_q + 4'd1;
                end
            end else begin
                wait_cnt_q <= '0;
            end
            // SETUP phase marks a new transfer
            if (apb_i.psel && !apb_i.penable) begin
                xfer_count_o <= xfer_count_o + 32'd1;
            end
        end
    end

    assign apb_o.pready  = ready;
    assign apb_o.prdata  = ready ? (apb_i.paddr ^ 32'h5a5a_0000) : '0;
    assign apb_o.pslverr = ready & slverr_i;

endmodule

//--- verilog/fetch_unit_top.sv
// Instruction fetch front end
// PC generator, branch target buffer, fetch controller and APB wait
// timer. Reads instruction words over APB and hands packets to decode.
`timescale 1ns/1ps

module fetch_unit_top
    import fetch_pkg::*;
#(
    parameter int BTB_ENTRIES    = 16,
    parameter int TIMEOUT_CYCLES = 32
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  addr_t           reset_addr_i,
    input  logic            stall_i,
    // From commit and execute
    input  redirect_t       redirect_i,
    input  branch_resolve_t resolve_i,
    // Instruction memory
    output apb_req_t        apb_o,
    input  apb_rsp_t        apb_i,
    // Decode
    output fetch_out_t      fetch_o,
    input  logic            fetch_ready_i
);

    addr_t        pc;
    logic         misaligned;
    bpred_t       bpred;
    next_pc_sel_e next_pc_sel;
    addr_t        jump_pc;
    logic         count_en;
    logic         expired;

    pc_gen i_pc_gen (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .sel_i        (next_pc_sel),
        .jump_pc_i    (jump_pc),
        .bpred_i      (bpred),
        .pc_o         (pc),
        .misaligned_o (misaligned)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_branch_predictor (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .pc_i      (pc),
        .resolve_i (resolve_i),
        .bpred_o   (bpred)
    );

    fetch_ctrl i_fetch_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .pc_i          (pc),
        .misaligned_i  (misaligned),
        .bpred_i       (bpred),
        .redirect_i    (redirect_i),
        .expired_i     (expired),
        .sel_o         (next_pc_sel),
        .jump_pc_o     (jump_pc),
        .count_en_o    (count_en),
        .apb_o         (apb_o),
        .apb_i         (apb_i),
        .fetch_o       (fetch_o),
        .fetch_ready_i (fetch_ready_i)
    );

    apb_wait_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_apb_wait_timer (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .count_en_i (count_en),
        .expired_o  (expired)
    );

endmodule

//--- verilog/apb_wait_timer.sv
// APB wait timer
// Counts cycles spent in the APB ACCESS phase and flags the access
// as expired once the count reaches TIMEOUT_CYCLES
`timescale 1ns/1ps

module apb_wait_timer #(
    parameter int TIMEOUT_CYCLES = 32
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic count_en_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;

    // Cleared outside ACCESS, stops at the limit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (!count_en_i) begin
            cnt_q <= '0;
        end else if (!expired_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign expired_o = (cnt_q == CNT_W'(TIMEOUT_CYCLES));

endmodule

//--- verilog/fetch_ctrl.sv
// Fetch controller
// FSM that runs APB read transfers for the current pc, holds the
// fetched packet until decode takes it, and drops the result of a
// transfer that a redirect has made stale. Bus errors, timeouts and
// misaligned pcs are reported in the packet.
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         stall_i,

    // From the PC generator and predictor
    input  addr_t        pc_i,
    input  logic         misaligned_i,
    input  bpred_t       bpred_i,

    input  redirect_t    redirect_i,
    // Access timeout
    input  logic         expired_i,

    // PC generator control
    output next_pc_sel_e sel_o,
    output addr_t        jump_pc_o,
    output logic         count_en_o,

    // APB requester
    output apb_req_t     apb_o,
    input  apb_rsp_t     apb_i,

    // Decode side
    output fetch_out_t   fetch_o,
    input  logic         fetch_ready_i
);

    fetch_state_e state_q, state_d;
    logic         discard_q, discard_d;
    // Transfer address, keeps paddr stable across a redirect
    addr_t        addr_q;

    // Held packet payload
    addr_t        pkt_pc_q;
    instr_t       pkt_instr_q;
    xcpt_t        pkt_ex_q;
    bpred_t       pkt_bpred_q;

    logic         capture;
    xcpt_t        ex_d;
    logic         bus_done;
    logic         bus_fault;

    // Transfer ends on pready or on timeout
    assign bus_done  = apb_i.pready | expired_i;
    // A completed transfer reports pslverr, a hung one always faults
    assign bus_fault = apb_i.pready ? apb_i.pslverr : expired_i;

    assign jump_pc_o = redirect_i.pc;

    always_comb begin
        state_d      = state_q;
        discard_d    = discard_q;
        sel_o        = NEXT_PC_KEEP;
        capture      = 1'b0;
        ex_d.valid   = 1'b0;
        ex_d.cause   = INSTR_ADDR_MISALIGNED;
        ex_d.origin  = pc_i;
        unique case (state_q)
            FETCH_IDLE: begin
                if (redirect_i.valid) begin
                    sel_o = NEXT_PC_JUMP;
                end else if (!stall_i) begin
                    if (misaligned_i) begin
                        // No bus access, report straight away
                        state_d    = FETCH_HOLD;
                        capture    = 1'b1;
                        ex_d.valid = 1'b1;
                    end else begin
                        state_d = FETCH_SETUP;
                    end
                end
            end
            FETCH_SETUP: begin
                if (misaligned_i) begin
                    // Predicted target not aligned, transfer suppressed
                    if (redirect_i.valid) begin
                        sel_o   = NEXT_PC_JUMP;
                        state_d = FETCH_IDLE;
                    end else begin
                        state_d    = FETCH_HOLD;
                        capture    = 1'b1;
                        ex_d.valid = 1'b1;
                    end
                end else begin
                    state_d = FETCH_ACCESS;
                    // Transfer has started, finish it and drop the data
                    if (redirect_i.valid) begin
                        sel_o     = NEXT_PC_JUMP;
                        discard_d = 1'b1;
                    end
                end
            end
            FETCH_ACCESS: begin
                ex_d.cause = INSTR_ACCESS_FAULT;
                if (redirect_i.valid) begin
                    sel_o     = NEXT_PC_JUMP;
                    discard_d = 1'b1;
                end
                if (bus_done) begin
                    discard_d = 1'b0;
                    if (discard_q || redirect_i.valid) begin
                        state_d = FETCH_IDLE;
                    end else begin
                        state_d    = FETCH_HOLD;
                        capture    = 1'b1;
                        ex_d.valid = bus_fault;
                    end
                end
            end
            FETCH_HOLD: begin
                if (redirect_i.valid) begin
                    // Held packet dropped
                    sel_o   = NEXT_PC_JUMP;
                    state_d = FETCH_IDLE;
                end else if (fetch_ready_i) begin
                    sel_o   = NEXT_PC_BP_OR_4;
                    state_d = stall_i ? FETCH_IDLE : FETCH_SETUP;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= FETCH_IDLE;
            discard_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            discard_q <= discard_d;
        end
    end

    // Address latched in SETUP for the ACCESS phase
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH_SETUP) begin
            addr_q <= pc_i;
        end
    end

    // Packet capture on entry to HOLD
    always_ff @(posedge clk_i) begin
        if (capture) begin
            pkt_pc_q    <= pc_i;
            pkt_instr_q <= (state_q == FETCH_ACCESS) ? apb_i.prdata : '0;
            pkt_ex_q    <= ex_d;
            pkt_bpred_q <= bpred_i;
        end
    end

    // APB read, psel dropped if SETUP finds a misaligned pc
    assign apb_o.psel    = ((state_q == FETCH_SETUP) & ~misaligned_i) |
                           (state_q == FETCH_ACCESS);
    assign apb_o.penable = (state_q == FETCH_ACCESS);
    assign apb_o.paddr   = (state_q == FETCH_ACCESS) ? addr_q : pc_i;

    assign count_en_o = (state_q == FETCH_ACCESS);

    // HOLD is the only state with a packet
    assign fetch_o.valid = (state_q == FETCH_HOLD);
    assign fetch_o.pc    = pkt_pc_q;
    assign fetch_o.instr = pkt_instr_q;
    assign fetch_o.ex    = pkt_ex_q;
    assign fetch_o.bpred = pkt_bpred_q;

endmodule

//--- verilog/branch_predictor.sv
// Branch predictor
// Tagged direct-mapped branch target buffer, one 2-bit saturating
// counter per entry. Looked up with the fetch pc, trained by branch
// resolutions from execute.
`timescale 1ns/1ps

module branch_predictor
    import fetch_pkg::*;
#(
    parameter int BTB_ENTRIES = 16
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  addr_t           pc_i,
    input  branch_resolve_t resolve_i,
    output bpred_t          bpred_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = ADDR_W - IDX_W - 2;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [1:0]       ctr;
        addr_t            target;
    } btb_entry_t;

    // Entry storage and per-entry valid bits
    btb_entry_t             btb_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    // Lookup side
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    btb_entry_t       rd_entry;
    logic             rd_hit;

    // Training side
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    btb_entry_t       wr_entry;
    logic             wr_hit;
    logic [1:0]       ctr_next;

    // Index above the byte offset, tag from the rest
    assign rd_idx   = pc_i[IDX_W+1:2];
    assign rd_tag   = pc_i[ADDR_W-1:IDX_W+2];
    assign rd_entry = btb_q[rd_idx];
    assign rd_hit   = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

    assign bpred_o.is_branch = rd_hit;
    // Counter MSB gives the direction
    assign bpred_o.taken     = rd_hit & rd_entry.ctr[1];
    assign bpred_o.pred_addr = rd_entry.target;

    assign wr_idx   = resolve_i.pc[IDX_W+1:2];
    assign wr_tag   = resolve_i.pc[ADDR_W-1:IDX_W+2];
    assign wr_entry = btb_q[wr_idx];
    assign wr_hit   = valid_q[wr_idx] && (wr_entry.tag == wr_tag);

    // Saturating up on taken, down on not taken
    always_comb begin
        ctr_next = wr_entry.ctr;
        if (resolve_i.taken) begin
            if (wr_entry.ctr != 2'b11) begin
                ctr_next = wr_entry.ctr + 2'b01;
            end
        end else if (wr_entry.ctr != 2'b00) begin
            ctr_next = wr_entry.ctr - 2'b01;
        end
    end

    // Valid bits, set on allocation of a taken miss
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (resolve_i.valid && resolve_i.taken && !wr_hit) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (resolve_i.valid) begin
            if (wr_hit) begin
                btb_q[wr_idx].target <= resolve_i.target;
                btb_q[wr_idx].ctr    <= ctr_next;
            end else if (resolve_i.taken) begin
                // New entry starts weakly taken
                btb_q[wr_idx].tag    <= wr_tag;
                btb_q[wr_idx].ctr    <= 2'b10;
                btb_q[wr_idx].target <= resolve_i.target;
            end
        end
    end

endmodule

//--- verilog/pc_gen.sv
// PC generator
// Holds the fetch address and selects the next one from keep, the
// predicted target or pc + 4, or a redirect from later stages.
// Also flags a fetch address that is not word aligned.
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  addr_t        reset_addr_i,

    // Source select from the fetch controller
    input  next_pc_sel_e sel_i,
    // Redirect target
    input  addr_t        jump_pc_i,
    // Prediction for the current pc
    input  bpred_t       bpred_i,

    output addr_t        pc_o,
    output logic         misaligned_o
);

    addr_t pc_q;
    addr_t next_pc;
    addr_t seq_pc;
    logic  follow_bp;

    // Sequential successor
    assign seq_pc = pc_q + 32'd4;

    // Only a hit predicted taken overrides pc + 4
    assign follow_bp = bpred_i.is_branch & bpred_i.taken;

    always_comb begin
        unique case (sel_i)
            NEXT_PC_KEEP: begin
                next_pc = pc_q;
            end
            NEXT_PC_BP_OR_4: begin
                if (follow_bp) begin
                    next_pc = bpred_i.pred_addr;
                end else begin
                    next_pc = seq_pc;
                end
            end
            NEXT_PC_JUMP: begin
                next_pc = jump_pc_i;
            end
            default: begin
                // Unused encoding, hold the pc
                next_pc = pc_q;
            end
        endcase
    end

    // Fetch PC register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

    // Instructions are 32-bit words, both low bits must be zero
    assign misaligned_o = |pc_q[1:0];

endmodule

//--- verilog/fetch_pkg.sv
// Fetch front end shared definitions
// Widths, enums and packed structs used by the PC generator, the branch
// predictor, the fetch controller and the APB requester port
package fetch_pkg;

    // Datapath widths
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INSTR_W-1:0] instr_t;

    // Next PC source chosen by the fetch controller
    typedef enum logic [1:0] {
        NEXT_PC_KEEP    = 2'd0,
        NEXT_PC_BP_OR_4 = 2'd1,
        NEXT_PC_JUMP    = 2'd2
    } next_pc_sel_e;

    // Fetch controller states
    typedef enum logic [1:0] {
        FETCH_IDLE   = 2'd0,
        FETCH_SETUP  = 2'd1,
        FETCH_ACCESS = 2'd2,
        FETCH_HOLD   = 2'd3
    } fetch_state_e;

    // Exception causes, RISC-V mcause encoding
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } ex_cause_e;

    typedef struct packed {
        logic      valid;
        ex_cause_e cause;
        addr_t     origin;
    } xcpt_t;

    // Prediction that travels with the fetched word
    typedef struct packed {
        logic  is_branch;
        logic  taken;
        addr_t pred_addr;
    } bpred_t;

    // PC change requested by commit or execute
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    // Branch outcome from execute, trains the predictor
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } branch_resolve_t;

    // APB requester side, read only
    typedef struct packed {
        logic  psel;
        logic  penable;
        addr_t paddr;
    } apb_req_t;

    // APB completer side
    typedef struct packed {
        logic   pready;
        instr_t prdata;
        logic   pslverr;
    } apb_rsp_t;

    // Packet handed to decode
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
        xcpt_t  ex;
        bpred_t bpred;
    } fetch_out_t;

endpackage
